//--- fmul.f
common/fp_format_pkg.sv
common/fmul_ctrl_pkg.sv
common/fmul_ctrl_if.sv
fmul/fmul_sequencer.sv
fmul/fmul_exponent_path.sv
fmul/fmul_significand_path.sv
src/fmul_top.sv
tests/fmul_assert.sv
tests/fmul_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = fmul_tb
FILELIST   = fmul.f
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_OPTS   = +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_OPTS) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/fmul_tb.sv
`timescale 1ns/100ps

module fmul_tb;
	import fp_format_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RANDOM = 40;
	localparam int N_OPS = N_RANDOM + 9;
	localparam int WATCHDOG_CYCLES = N_OPS * 20 + RESET_CYCLES;

	logic clk = 1'b0;
	logic rst;
	logic begin_i;
	logic ack_i;
	fp_word_t a_i;
	fp_word_t b_i;
	fp_word_t result_o;
	logic ready_o;
	logic busy_o;

	logic [15:0] lfsr;
	int checks;
	int errors;
	int tests;
	int chk_mark;
	int err_mark;

	fmul_top u_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic random_operand(output fp_word_t w);
		logic [31:0] s;
		logic [31:0] e;
		logic [31:0] f;
		draw_bits(1, s);
		draw_bits(7, e);
		draw_bits(23, f);
		w = {s[0], 8'(64 + e % 127), f[22:0]}; // exponent 64 to 190.
	endtask

	// exact product, normalize, add half at the guard bit, truncate.
	function automatic fp_word_t expected_product(input fp_word_t a, input fp_word_t b);
		logic sign;
		int e;
		prod_t p;
		sign = a[31] ^ b[31];
		if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
			return {sign, 31'd0};
		p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
		e = a[30:23] + b[30:23] - 127;
		if (p[47])
		begin
			p = p >> 1;
			e = e + 1;
		end
		p = p + 48'h40_0000;
		if (p[47])
		begin
			p = p >> 1; // carry out of the rounding.
			e = e + 1;
		end
		return {sign, e[7:0], p[45:23]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("** Error at %0t: %s is %08h, expected %08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic start_op(input fp_word_t a, input fp_word_t b);
		next_cycle();
		a_i = a;
		b_i = b;
		begin_i = 1'b1;
		next_cycle();
		begin_i = 1'b0;
	endtask

	task automatic wait_ready();
		while (!ready_o)
		begin
			check_value("busy while running", 32'(busy_o), 32'd1);
			next_cycle();
		end
	endtask

	task automatic acknowledge();
		ack_i = 1'b1;
		next_cycle();
		ack_i = 1'b0;
		check_value("ready after ack", 32'(ready_o), 32'd0);
	endtask

	task automatic run_check(input string name, input fp_word_t a, input fp_word_t b);
		start_op(a, b);
		wait_ready();
		check_value(name, result_o, expected_product(a, b));
		acknowledge();
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the DUT did not finish all operations in time");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		fp_word_t a;
		fp_word_t b;
		fp_word_t held;
		int total;
		lfsr = 16'd32859;
		rst = 1'b1;
		begin_i = 1'b0;
		ack_i = 1'b0;
		a_i = '0;
		b_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5;
		rst = 1'b0;
		check_value("reset result", result_o, 32'd0);
		check_value("reset flags", {30'd0, ready_o, busy_o}, 32'd0);
		end_test("reset");

		run_check("1.25 x 1.5", 32'h3FA0_0000, 32'h3FC0_0000);
		run_check("-1.5 x 1.5", 32'hBFC0_0000, 32'h3FC0_0000);
		end_test("directed");

		// the first pair carries out of the rounding and the second normalizes.
		run_check("round carry", 32'h3FFF_FFFE, 32'h3F80_0001);
		run_check("round norm", 32'h3FFF_FFFF, 32'h3F80_0001);
		end_test("rounding");

		for (int i = 0; i < N_RANDOM; i++)
		begin
			random_operand(a);
			random_operand(b);
			run_check("random", a, b);
		end
		end_test("random");

		random_operand(b);
		run_check("zero a", 32'h0000_0000, b);
		run_check("zero b", b, 32'h8000_0000);
		run_check("neg zero", 32'h8000_0000, 32'hBFC0_0000);
		run_check("zero zero", 32'h0000_0000, 32'h0000_0000);
		end_test("zero");

		random_operand(a);
		random_operand(b);
		start_op(a, b);
		next_cycle();
		a_i = '0; // a restart would give a zero result.
		begin_i = 1'b1;
		next_cycle();
		begin_i = 1'b0;
		wait_ready();
		held = result_o;
		check_value("handshake", held, expected_product(a, b));
		begin_i = 1'b1;
		next_cycle();
		begin_i = 1'b0;
		check_value("ready held", 32'(ready_o), 32'd1);
		check_value("result held", result_o, held);
		acknowledge();
		end_test("handshake");

		total = errors + u_dut.u_assert.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, u_dut.u_assert.fail_cnt);
		if (total == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tests/fmul_assert.sv
`timescale 1ns/100ps

module fmul_assert (
	input logic clk,
	input logic rst,
	input logic begin_i,
	input logic ack_i,
	input fp_format_pkg::fp_word_t a_i,
	input fp_format_pkg::fp_word_t b_i,
	input fp_format_pkg::fp_word_t result_i,
	input logic ready_i,
	input logic busy_i,
	input fmul_ctrl_pkg::fmul_state_e state_i
);
	import fp_format_pkg::*;
	import fmul_ctrl_pkg::*;

	int fail_cnt;
	logic zero_op;

	assign zero_op = (a_i[MAN_W +: EXP_W] == '0) || (b_i[MAN_W +: EXP_W] == '0);

	ready_busy_excl: assert property (@(posedge clk) disable iff (rst)
		!(ready_i && busy_i))
	else
	begin
		$error("ready and busy high together");
		fail_cnt++;
	end

	// zero path: LOAD_OPS, SETTLE, ADD_EXP, SUB_BIAS, then DONE.
	zero_latency: assert property (@(posedge clk) disable iff (rst)
		(state_i == IDLE && begin_i && zero_op)
		|=> !ready_i ##1 !ready_i ##1 !ready_i ##1 !ready_i ##1 ready_i)
	else
	begin
		$error("zero operand ready latency is not 5 cycles");
		fail_cnt++;
	end

	ready_hold: assert property (@(posedge clk) disable iff (rst)
		(state_i == DONE && !ack_i) |=> (state_i == DONE && $stable(result_i)))
	else
	begin
		$error("result left DONE or changed without ack");
		fail_cnt++;
	end

	ack_release: assert property (@(posedge clk) disable iff (rst)
		(state_i == DONE && ack_i) |=> (state_i == IDLE && !ready_i))
	else
	begin
		$error("ack did not return the sequencer to IDLE");
		fail_cnt++;
	end

	busy_begin_ignored: assert property (@(posedge clk) disable iff (rst)
		(busy_i && begin_i) |=> (state_i != LOAD_OPS))
	else
	begin
		$error("begin accepted while busy");
		fail_cnt++;
	end

endmodule

bind fmul_top fmul_assert u_assert (
	.clk      (clk),
	.rst      (rst),
	.begin_i  (begin_i),
	.ack_i    (ack_i),
	.a_i      (a_i),
	.b_i      (b_i),
	.result_i (result_o),
	.ready_i  (ready_o),
	.busy_i   (busy_o),
	.state_i  (u_seq.state_q)
);

//--- src/fmul_top.sv
`timescale 1ns/100ps

module fmul_top (
	input logic clk,
	input logic rst,
	input logic begin_i,
	input logic ack_i,
	input fp_format_pkg::fp_word_t a_i,
	input fp_format_pkg::fp_word_t b_i,
	output fp_format_pkg::fp_word_t result_o,
	output logic ready_o,
	output logic busy_o
);
	import fp_format_pkg::*;

	exp_t res_exp;
	logic res_sign;
	logic [MAN_W-1:0] res_frac;

	fmul_ctrl_if u_ctrl_if ();

	fmul_sequencer u_seq (
		.clk     (clk),
		.rst     (rst),
		.begin_i (begin_i),
		.ack_i   (ack_i),
		.ready_o (ready_o),
		.busy_o  (busy_o),
		.ctrl    (u_ctrl_if.seq)
	);

	fmul_exponent_path u_exp (
		.clk    (clk),
		.rst    (rst),
		.a_i    (a_i),
		.b_i    (b_i),
		.ctrl   (u_ctrl_if.exp_dp),
		.exp_o  (res_exp),
		.sign_o (res_sign)
	);

	fmul_significand_path u_sig (
		.clk   (clk),
		.rst   (rst),
		.ctrl  (u_ctrl_if.sig_dp),
		.sig_o (res_frac)
	);

	// no overflow flag, the spare exponent bit is dropped.
	assign result_o = {res_sign, res_exp[EXP_W-1:0], res_frac};

endmodule

//--- fmul/fmul_significand_path.sv
`timescale 1ns/100ps

module fmul_significand_path (
	input logic clk,
	input logic rst,
	fmul_ctrl_if.sig_dp ctrl,
	output logic [fp_format_pkg::MAN_W-1:0] sig_o
);
	import fp_format_pkg::*;

	prod_t raw_prod;
	prod_t prod_q;
	prod_t rnd_sum;
	logic ovf_q;

	// combinational from the operand registers.
	assign raw_prod = prod_t'(ctrl.sig_a) * prod_t'(ctrl.sig_b);

	assign ctrl.norm_needed = raw_prod[PROD_W-1]; // product >= 2.0.

	// hidden bit sits at PROD_W-2 after normalization, guard just below the fraction.
	assign ctrl.round_needed = prod_q[MAN_W-1];

	// half ulp added at the guard bit, ties away from zero.
	assign rnd_sum = prod_q + (prod_t'(1) << (MAN_W - 1));

	always_ff @(posedge clk)
	begin
		if (ctrl.clear)
			prod_q <= '0;
		else if (ctrl.load_prod)
			prod_q <= ctrl.shift_norm ? raw_prod >> 1 : raw_prod;
		else if (ctrl.load_round)
			prod_q <= rnd_sum;
		else if (ctrl.shift_norm)
			prod_q <= prod_q >> 1; // renormalize after a rounding carry.
	end

	// carry above the hidden bit.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			ovf_q <= 1'b0;
		else if (ctrl.clear || ctrl.load_prod)
			ovf_q <= 1'b0;
		else if (ctrl.load_round)
			ovf_q <= rnd_sum[PROD_W-1];
	end

	assign ctrl.round_ovf = ovf_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			sig_o <= '0;
		else if (ctrl.load_result)
			sig_o <= ctrl.zero_flag ? '0 : prod_q[PROD_W-3 -: MAN_W];
	end

endmodule

//--- fmul/fmul_exponent_path.sv
`timescale 1ns/100ps

module fmul_exponent_path (
	input logic clk,
	input logic rst,
	input fp_format_pkg::fp_word_t a_i,
	input fp_format_pkg::fp_word_t b_i,
	fmul_ctrl_if.exp_dp ctrl,
	output fp_format_pkg::exp_t exp_o,
	output logic sign_o
);
	import fp_format_pkg::*;
	import fmul_ctrl_pkg::*;

	fp_word_t a_q;
	fp_word_t b_q;
	logic sign_q;
	exp_t exp_q;
	exp_t opnd_x;
	exp_t opnd_y;
	exp_t exp_sum;
	logic [EXP_W-1:0] exp_a;
	logic [EXP_W-1:0] exp_b;

	assign exp_a = a_q[MAN_W +: EXP_W];
	assign exp_b = b_q[MAN_W +: EXP_W];

	always_ff @(posedge clk)
	begin
		if (ctrl.load_ops)
		begin
			a_q <= a_i;
			b_q <= b_i;
			sign_q <= a_i[WORD_W-1] ^ b_i[WORD_W-1];
		end
	end

	// denormals are not supported, a zero exponent field counts as zero.
	assign ctrl.zero_flag = (exp_a == '0) || (exp_b == '0);

	assign ctrl.sig_a = {|exp_a, a_q[MAN_W-1:0]};
	assign ctrl.sig_b = {|exp_b, b_q[MAN_W-1:0]};

	// shared adder/subtractor.
	always_comb
	begin
		opnd_x = (ctrl.exp_sel == EXP_SEL_B) ? exp_t'(exp_a) : exp_q;
		case (ctrl.exp_sel)
			EXP_SEL_B:    opnd_y = exp_t'(exp_b);
			EXP_SEL_BIAS: opnd_y = exp_t'(EXP_BIAS);
			EXP_SEL_ONE:  opnd_y = exp_t'(1);
			default:      opnd_y = '0;
		endcase
		exp_sum = ctrl.exp_sub ? opnd_x - opnd_y : opnd_x + opnd_y;
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.clear)
			exp_q <= '0;
		else if (ctrl.load_exp)
			exp_q <= exp_sum;
	end

	// result exponent and sign.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			exp_o <= '0;
			sign_o <= 1'b0;
		end
		else if (ctrl.load_result)
		begin
			exp_o <= ctrl.zero_flag ? '0 : exp_q;
			sign_o <= sign_q;
		end
	end

endmodule

//--- fmul/fmul_sequencer.sv
`timescale 1ns/100ps

module fmul_sequencer (
	input logic clk,
	input logic rst,
	input logic begin_i,
	input logic ack_i,
	output logic ready_o,
	output logic busy_o,
	fmul_ctrl_if.seq ctrl
);
	import fmul_ctrl_pkg::*;

	fmul_state_e state_q;
	fmul_state_e state_d;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		ctrl.load_ops = 1'b0;
		ctrl.load_exp = 1'b0;
		ctrl.load_prod = 1'b0;
		ctrl.load_round = 1'b0;
		ctrl.load_result = 1'b0;
		ctrl.exp_sel = EXP_SEL_B;
		ctrl.exp_sub = 1'b0;
		ctrl.shift_norm = 1'b0;
		ctrl.clear = 1'b0;
		ready_o = 1'b0;
		busy_o = 1'b1;

		case (state_q)
			IDLE:
			begin
				busy_o = 1'b0;
				ctrl.clear = 1'b1;
				if (begin_i)
					state_d = LOAD_OPS;
			end
			LOAD_OPS:
			begin
				ctrl.load_ops = 1'b1;
				state_d = SETTLE;
			end
			SETTLE:
				state_d = ADD_EXP; // product settles from the new operands.
			ADD_EXP:
			begin
				ctrl.load_exp = 1'b1;
				ctrl.exp_sel = EXP_SEL_B;
				state_d = SUB_BIAS;
			end
			SUB_BIAS:
			begin
				ctrl.load_exp = 1'b1;
				ctrl.exp_sel = EXP_SEL_BIAS;
				ctrl.exp_sub = 1'b1;
				if (ctrl.zero_flag)
				begin
					ctrl.load_result = 1'b1; // signed zero, skip the rest.
					state_d = DONE;
				end
				else
					state_d = MULT_CHECK;
			end
			MULT_CHECK:
			begin
				if (ctrl.norm_needed)
					state_d = NORM_SHIFT;
				else
					state_d = NO_SHIFT;
			end
			NORM_SHIFT:
			begin
				ctrl.load_prod = 1'b1;
				ctrl.shift_norm = 1'b1;
				ctrl.load_exp = 1'b1;
				ctrl.exp_sel = EXP_SEL_ONE;
				state_d = ROUND_CHECK;
			end
			NO_SHIFT:
			begin
				ctrl.load_prod = 1'b1;
				state_d = ROUND_CHECK;
			end
			ROUND_CHECK:
			begin
				if (ctrl.round_needed)
					state_d = ROUND_ADD;
				else
					state_d = FINAL_LOAD;
			end
			ROUND_ADD:
			begin
				ctrl.load_round = 1'b1;
				state_d = ROUND_NORM;
			end
			ROUND_NORM:
			begin
				// carry out of the rounding adder, shift back and bump exponent.
				if (ctrl.round_ovf)
				begin
					ctrl.shift_norm = 1'b1;
					ctrl.load_exp = 1'b1;
					ctrl.exp_sel = EXP_SEL_ONE;
				end
				state_d = FINAL_LOAD;
			end
			FINAL_LOAD:
			begin
				ctrl.load_result = 1'b1;
				state_d = DONE;
			end
			DONE:
			begin
				busy_o = 1'b0;
				ready_o = 1'b1;
				if (ack_i)
					state_d = IDLE;
			end
			default:
			begin
				busy_o = 1'b0;
				state_d = IDLE;
			end
		endcase
	end

endmodule

//--- common/fmul_ctrl_if.sv
`timescale 1ns/100ps

interface fmul_ctrl_if;
	import fp_format_pkg::*;
	import fmul_ctrl_pkg::*;

	// strobes and selects from the sequencer.
	logic load_ops;
	logic load_exp;
	logic load_prod;
	logic load_round;
	logic load_result;
	exp_sel_e exp_sel;
	logic exp_sub;
	logic shift_norm;
	logic clear;

	// status back to the sequencer.
	logic zero_flag;
	logic norm_needed;
	logic round_needed;
	logic round_ovf;

	sig_t sig_a; // operand significands, hidden bit set.
	sig_t sig_b;

	modport seq (
		output load_ops, load_exp, load_prod, load_round, load_result,
		output exp_sel, exp_sub, shift_norm, clear,
		input zero_flag, norm_needed, round_needed, round_ovf
	);

	modport exp_dp (
		input load_ops, load_exp, load_result, exp_sel, exp_sub, clear,
		output zero_flag, sig_a, sig_b
	);

	modport sig_dp (
		input load_prod, load_round, load_result, shift_norm, clear,
		input zero_flag, sig_a, sig_b,
		output norm_needed, round_needed, round_ovf
	);

endinterface

//--- common/fmul_ctrl_pkg.sv
package fmul_ctrl_pkg;

	typedef enum logic [3:0] {
		IDLE        = 4'd0,
		LOAD_OPS    = 4'd1,
		SETTLE      = 4'd2,
		ADD_EXP     = 4'd3,
		SUB_BIAS    = 4'd4,
		MULT_CHECK  = 4'd5,
		NORM_SHIFT  = 4'd6,
		NO_SHIFT    = 4'd7,
		ROUND_CHECK = 4'd8,
		ROUND_ADD   = 4'd9,
		ROUND_NORM  = 4'd10,
		FINAL_LOAD  = 4'd11,
		DONE        = 4'd12
	} fmul_state_e;

	// second input of the exponent adder.
	typedef enum logic [1:0] {
		EXP_SEL_B    = 2'd0,
		EXP_SEL_BIAS = 2'd1,
		EXP_SEL_ONE  = 2'd2
	} exp_sel_e;

endpackage

//--- common/fp_format_pkg.sv
package fp_format_pkg;

	// ieee 754 single precision fields.
	localparam int EXP_W = 8;
	localparam int MAN_W = 23;
	localparam int SIG_W = MAN_W + 1; // hidden bit included.
	localparam int WORD_W = 1 + EXP_W + MAN_W;
	localparam int PROD_W = 2 * SIG_W;

	localparam int EXP_BIAS = 127;

	// packed float: sign, biased exponent, fraction.
	typedef logic [WORD_W-1:0] fp_word_t;

	// one spare bit so ea + eb fits before the bias subtract.
	typedef logic [EXP_W:0] exp_t;

	typedef logic [SIG_W-1:0] sig_t;

	// full 24 x 24 significand product.
	typedef logic [PROD_W-1:0] prod_t;

endpackage
